// ==== sources.f ====
lock_pkg.sv
entry_if.sv
key_decoder.sv
entry_buffer.sv
lock_ctrl.sv
buzzer_gen.sv
code_lock_top.sv
code_lock_props.sv
tb_code_lock.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP       ?= tb_code_lock
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_code_lock.sv ====
`default_nettype none

module tb_code_lock;

    timeunit 1ns;
    timeprecision 100ps;

    import lock_pkg::*;

    localparam int TICK_CYCLES  = 8;
    localparam int PRESSES      = 42;
    localparam int LOCK_CYCLES  = (5 + 2) * TICK_CYCLES;  // 005 countdown and return
    localparam int LIMIT_CYCLES = PRESSES * 4 + LOCK_CYCLES + 200;

    // keypad bit for each key code in key_t order
    localparam int KEY_BIT [0:13] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13, 0, 12, 8, 4};

    logic        clk;
    logic        arst_n;
    logic [15:0] onehot;
    logic [11:0] display;
    logic [1:0]  tries;
    logic        unlocked;
    logic        locked_out;
    logic        buzzer;

    integer      seed;
    int          errors;
    logic [11:0] secret;  // code the lock holds
    logic [11:0] code;

    code_lock_top #(
        .TICK_CYCLES    (TICK_CYCLES),
        .DEFAULT_SECRET (12'h246),
        .CLICK_LEN      (10),
        .OK_LEN         (30),
        .FAIL_LEN       (15),
        .TICK_LEN       (10),
        .CLICK_HALF     (2),
        .OK_HALF        (3),
        .FAIL_HALF      (2),
        .TICK_HALF      (2)
    ) dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .onehot     (onehot),
        .display    (display),
        .tries      (tries),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hold the key 2 cycles and release it 2 cycles
    task automatic press(input int k);
        onehot = 16'(1) << KEY_BIT[k];
        repeat (2) @(negedge clk);
        onehot = 16'h0000;
        repeat (2) @(negedge clk);
    endtask

    task automatic enter_code(input logic [11:0] c);
        press(int'(c[11:8]));  // oldest digit first
        press(int'(c[7:4]));
        press(int'(c[3:0]));
        press(int'(KEY_ENTER));
    endtask

    task automatic draw_code(input logic [11:0] avoid, output logic [11:0] c);
        do begin
            c[11:8] = 4'($unsigned($random(seed)) % 10);
            c[7:4]  = 4'($unsigned($random(seed)) % 10);
            c[3:0]  = 4'($unsigned($random(seed)) % 10);
        end while (c == avoid);
    endtask

    task automatic check_port(input string name, input logic [11:0] got,
                              input logic [11:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    initial begin
        seed   = 32'hc661_7337;
        errors = 0;
        secret = 12'h246;
        code   = 12'h000;
        arst_n = 1'b0;
        onehot = 16'h0000;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        check_port("display", display, DISP_IDLE);

        enter_code(secret);  // default code
        check_port("unlocked", unlocked, 1'b1);
        press(int'(KEY_CLEAR));

        press(1);
        press(3);
        press(int'(KEY_BACK));
        press(5);
        press(7);
        press(9);  // dropped by the full buffer
        check_port("display", display, 12'h157);
        press(int'(KEY_BACK));
        press(int'(KEY_BACK));
        press(int'(KEY_BACK));
        press(int'(KEY_CLEAR));

        repeat (int'(MAX_TRIES)) begin
            draw_code(secret, code);
            enter_code(code);
        end
        check_port("locked_out", locked_out, 1'b1);
        check_port("display", display, 12'h005);
        press(8);  // ignored during lockout
        press(0);
        while (locked_out) begin
            @(negedge clk);
        end
        check_port("display", display, DISP_IDLE);
        repeat (16) @(negedge clk);

        press(int'(KEY_SET));
        check_port("display", display, DISP_SET);
        draw_code(secret, code);
        enter_code(code);
        check_port("unlocked", unlocked, 1'b0);
        enter_code(secret);  // old code no longer opens
        check_port("unlocked", unlocked, 1'b0);
        check_port("tries", tries, 2'd1);
        secret = code;
        enter_code(secret);

        repeat (40) @(negedge clk);
        check_port("unlocked", unlocked, 1'b1);
        check_port("locked_out", locked_out, 1'b0);
        check_port("tries", tries, 2'd0);
        check_port("display", display, DISP_OPEN);
        check_port("buzzer", buzzer, 1'b0);

        $display("Summary: %0d port mismatches, %0d assertion failures",
                 errors, dut0.u_props.fails);
        if ((errors == 0) && (dut0.u_props.fails == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== code_lock_props.sv ====
`default_nettype none

module code_lock_props #(
    parameter int          TICK_CYCLES    = 8,
    parameter logic [11:0] DEFAULT_SECRET = 12'h246,
    parameter int          CLICK_LEN      = 10,
    parameter int          OK_LEN         = 30,
    parameter int          FAIL_LEN       = 15,
    parameter int          TICK_LEN       = 10,
    parameter int          CLICK_HALF     = 2,
    parameter int          OK_HALF        = 3,
    parameter int          FAIL_HALF      = 2,
    parameter int          TICK_HALF      = 2
) (
    input wire logic           clk,
    input wire logic           arst_n,
    input wire logic [11:0]    display,
    input wire logic [1:0]     tries,
    input wire logic           unlocked,
    input wire logic           locked_out,
    input wire logic           buzzer,
    input wire lock_pkg::key_t key,
    input wire logic           key_valid,
    input wire logic           tone_req
);

    timeunit 1ns;
    timeprecision 100ps;

    import lock_pkg::*;

    localparam int HALF_A   = (CLICK_HALF > OK_HALF) ? CLICK_HALF : OK_HALF;
    localparam int HALF_B   = (FAIL_HALF > TICK_HALF) ? FAIL_HALF : TICK_HALF;
    localparam int MAX_HALF = (HALF_A > HALF_B) ? HALF_A : HALF_B;
    localparam int LEN_A    = (CLICK_LEN > OK_LEN) ? CLICK_LEN : OK_LEN;
    localparam int LEN_B    = (FAIL_LEN > TICK_LEN) ? FAIL_LEN : TICK_LEN;
    localparam int MAX_LEN  = (LEN_A > LEN_B) ? LEN_A : LEN_B;

    logic        digit_ok;   // digit the buffer must take
    logic        in_set;     // set mode seen on the display
    logic [11:0] secret;     // code the lock should accept
    logic [1:0]  lock_n;     // lockouts so far
    logic        lo_q;
    logic [11:0] disp_q;
    int          since_chg;  // cycles since last display change
    int          hi_run;     // consecutive high buzzer cycles
    int          quiet;      // cycles since last tone request
    int          fails = 0;

    function automatic logic [11:0] bcd_minus_one(input logic [11:0] v);
        int n;
        n = v[11:8] * 100 + v[7:4] * 10 + v[3:0] - 1;
        return {4'(n / 100), 4'((n / 10) % 10), 4'(n % 10)};
    endfunction

    assign digit_ok = key_valid && (key <= KEY_9) && !unlocked && !locked_out
                    && (display[11:8] == DIGIT_BLANK);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_set    <= 1'b0;
            secret    <= DEFAULT_SECRET;
            lock_n    <= 2'd0;
            lo_q      <= 1'b0;
            disp_q    <= DISP_IDLE;
            since_chg <= 0;
            hi_run    <= 0;
            quiet     <= 0;
        end else begin
            if (display == DISP_SET) begin
                in_set <= 1'b1;
            end
            if (in_set && key_valid && (key == KEY_ENTER) && (display != DISP_SET)
                && (display[11:8] != DIGIT_BLANK)) begin
                secret <= display;  // code stored from set mode
                in_set <= 1'b0;
            end else if (key_valid && (key == KEY_CLEAR)) begin
                in_set <= 1'b0;
            end
            if (locked_out && !lo_q && (lock_n != 2'd3)) begin
                lock_n <= lock_n + 2'd1;
            end
            lo_q      <= locked_out;
            disp_q    <= display;
            since_chg <= (display != disp_q) ? 0 : since_chg + 1;
            hi_run    <= buzzer ? hi_run + 1 : 0;
            if (tone_req) begin
                quiet <= 0;
            end else if (quiet <= MAX_LEN) begin
                quiet <= quiet + 1;
            end
        end
    end

    a_digit_shift: assert property (@(posedge clk) disable iff (!arst_n)
        digit_ok |=> (display[3:0] == $past(key)) && (display[7:4] == $past(display[3:0])))
        else begin
            $error("new digit did not shift into the display");
            fails++;
        end

    // backspace with two or more digits held
    a_backspace: assert property (@(posedge clk) disable iff (!arst_n)
        key_valid && (key == KEY_BACK) && !unlocked && !locked_out
        && (display[7:4] != DIGIT_BLANK) && (display != DISP_SET)
        |=> display[3:0] == $past(display[7:4]))
        else begin
            $error("backspace did not remove the newest digit");
            fails++;
        end

    a_open: assert property (@(posedge clk) disable iff (!arst_n)
        key_valid && (key == KEY_ENTER) && !in_set && !unlocked && !locked_out
        && (display == secret)
        |=> unlocked && (display == DISP_OPEN))
        else begin
            $error("correct code did not open the lock");
            fails++;
        end

    a_wrong: assert property (@(posedge clk) disable iff (!arst_n)
        key_valid && (key == KEY_ENTER) && !in_set && !unlocked && !locked_out
        && (display[11:8] != DIGIT_BLANK) && (display != secret)
        |=> !unlocked && (locked_out ? (tries == 2'd0) : (tries == $past(tries) + 2'd1)))
        else begin
            $error("wrong code was not counted as a failed attempt");
            fails++;
        end

    a_lock_load: assert property (@(posedge clk) disable iff (!arst_n)
        locked_out && !lo_q |-> (display == LOCKOUT_BCD[lock_n]) && (tries == 2'd0))
        else begin
            $error("lockout started with the wrong countdown");
            fails++;
        end

    a_countdown: assert property (@(posedge clk) disable iff (!arst_n)
        locked_out && lo_q && (display != disp_q)
        |-> (display == bcd_minus_one(disp_q)) && (since_chg == TICK_CYCLES - 1))
        else begin
            $error("lockout countdown step was wrong");
            fails++;
        end

    a_lock_end: assert property (@(posedge clk) disable iff (!arst_n)
        !locked_out && lo_q |-> (disp_q == 12'h000) && (display == DISP_IDLE))
        else begin
            $error("lockout ended before the countdown reached zero");
            fails++;
        end

    a_click: assert property (@(posedge clk) disable iff (!arst_n)
        $past(digit_ok, 2) |-> buzzer && !$past(buzzer))
        else begin
            $error("buzzer did not rise after an accepted digit");
            fails++;
        end

    a_half: assert property (@(posedge clk) disable iff (!arst_n)
        buzzer |-> hi_run < MAX_HALF)
        else begin
            $error("buzzer stayed high longer than a half period");
            fails++;
        end

    a_silent: assert property (@(posedge clk) disable iff (!arst_n)
        quiet > MAX_LEN |-> !buzzer)
        else begin
            $error("buzzer sounded after the tone should have ended");
            fails++;
        end

endmodule

bind code_lock_top code_lock_props #(
    .TICK_CYCLES    (TICK_CYCLES),
    .DEFAULT_SECRET (DEFAULT_SECRET),
    .CLICK_LEN      (CLICK_LEN),
    .OK_LEN         (OK_LEN),
    .FAIL_LEN       (FAIL_LEN),
    .TICK_LEN       (TICK_LEN),
    .CLICK_HALF     (CLICK_HALF),
    .OK_HALF        (OK_HALF),
    .FAIL_HALF      (FAIL_HALF),
    .TICK_HALF      (TICK_HALF)
) u_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .display    (display),
    .tries      (tries),
    .unlocked   (unlocked),
    .locked_out (locked_out),
    .buzzer     (buzzer),
    .key        (key),
    .key_valid  (key_valid),
    .tone_req   (tone_req)
);

`default_nettype wire

// ==== code_lock_top.sv ====
`default_nettype none

module code_lock_top #(
    parameter int          TICK_CYCLES    = 50_000_000,
    parameter logic [11:0] DEFAULT_SECRET = 12'h246,
    parameter int          CLICK_LEN      = 10_000_000,
    parameter int          OK_LEN         = 30_000_000,
    parameter int          FAIL_LEN       = 15_000_000,
    parameter int          TICK_LEN       = 5_000_000,
    parameter int          CLICK_HALF     = 50_000,
    parameter int          OK_HALF        = 25_000,
    parameter int          FAIL_HALF      = 100_000,
    parameter int          TICK_HALF      = 100_000
) (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic [15:0] onehot,
    output logic [11:0]      display,
    output logic [1:0]       tries,
    output logic             unlocked,
    output logic             locked_out,
    output logic             buzzer
);

    import lock_pkg::*;

    key_t  key;
    logic  key_valid;
    logic  tone_req;
    tone_t tone;

    entry_if ent_if ();

    key_decoder u_dec (
        .clk       (clk),
        .arst_n    (arst_n),
        .onehot    (onehot),
        .key       (key),
        .key_valid (key_valid)
    );

    entry_buffer u_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .key       (key),
        .key_valid (key_valid),
        .ent       (ent_if.buffer)
    );

    lock_ctrl #(
        .TICK_CYCLES    (TICK_CYCLES),
        .DEFAULT_SECRET (DEFAULT_SECRET)
    ) u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .key        (key),
        .key_valid  (key_valid),
        .ent        (ent_if.ctrl),
        .display    (display),
        .tries      (tries),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .tone_req   (tone_req),
        .tone       (tone)
    );

    buzzer_gen #(
        .CLICK_LEN  (CLICK_LEN),
        .OK_LEN     (OK_LEN),
        .FAIL_LEN   (FAIL_LEN),
        .TICK_LEN   (TICK_LEN),
        .CLICK_HALF (CLICK_HALF),
        .OK_HALF    (OK_HALF),
        .FAIL_HALF  (FAIL_HALF),
        .TICK_HALF  (TICK_HALF)
    ) u_buzz (
        .clk      (clk),
        .arst_n   (arst_n),
        .tone_req (tone_req),
        .tone     (tone),
        .buzzer   (buzzer)
    );

endmodule

`default_nettype wire

// ==== buzzer_gen.sv ====
`default_nettype none

module buzzer_gen #(
    parameter int CLICK_LEN  = 10_000_000,
    parameter int OK_LEN     = 30_000_000,
    parameter int FAIL_LEN   = 15_000_000,
    parameter int TICK_LEN   = 5_000_000,
    parameter int CLICK_HALF = 50_000,
    parameter int OK_HALF    = 25_000,
    parameter int FAIL_HALF  = 100_000,
    parameter int TICK_HALF  = 100_000
) (
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            tone_req,
    input  wire lock_pkg::tone_t tone,
    output logic                 buzzer
);

    import lock_pkg::*;

    localparam int MAX_A   = (CLICK_LEN > OK_LEN) ? CLICK_LEN : OK_LEN;
    localparam int MAX_B   = (FAIL_LEN > TICK_LEN) ? FAIL_LEN : TICK_LEN;
    localparam int MAX_LEN = (MAX_A > MAX_B) ? MAX_A : MAX_B;
    localparam int CW      = $clog2(MAX_LEN + 1);

    tone_t         tone_q;
    logic          active_q;
    logic          phase_q;   // square wave level
    logic [CW-1:0] dur_q;     // cycles since request
    logic [CW-1:0] half_q;    // cycles in this half-period
    logic [CW-1:0] len_sel;
    logic [CW-1:0] half_sel;
    logic          mute;

    always_comb begin
        case (tone_q)
            TONE_OK: begin
                len_sel  = CW'(OK_LEN);
                half_sel = CW'(OK_HALF);
            end
            TONE_FAIL: begin
                len_sel  = CW'(FAIL_LEN);
                half_sel = CW'(FAIL_HALF);
            end
            TONE_TICK: begin
                len_sel  = CW'(TICK_LEN);
                half_sel = CW'(TICK_HALF);
            end
            default: begin
                len_sel  = CW'(CLICK_LEN);
                half_sel = CW'(CLICK_HALF);
            end
        endcase
    end

    // fail tone is silent in its middle third
    assign mute = (tone_q == TONE_FAIL) && (dur_q > CW'(FAIL_LEN / 3))
                && (dur_q < CW'((2 * FAIL_LEN) / 3));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tone_q   <= TONE_CLICK;
            active_q <= 1'b0;
            phase_q  <= 1'b0;
            dur_q    <= '0;
            half_q   <= '0;
        end else if (tone_req) begin
            tone_q   <= tone;  // a request always restarts
            active_q <= 1'b1;
            phase_q  <= 1'b1;
            dur_q    <= '0;
            half_q   <= '0;
        end else if (active_q) begin
            dur_q <= dur_q + 1'b1;
            if (half_q == half_sel - 1'b1) begin
                half_q  <= '0;
                phase_q <= ~phase_q;
            end else begin
                half_q <= half_q + 1'b1;
            end
            if (dur_q == len_sel - 1'b1) begin
                active_q <= 1'b0;  // tone over
                phase_q  <= 1'b0;
            end
        end
    end

    assign buzzer = active_q && phase_q && !mute;

endmodule

`default_nettype wire

// ==== lock_ctrl.sv ====
`default_nettype none

module lock_ctrl #(
    parameter int          TICK_CYCLES    = 50_000_000,
    parameter logic [11:0] DEFAULT_SECRET = 12'h246
) (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire lock_pkg::key_t key,
    input  wire logic           key_valid,
    entry_if.ctrl               ent,
    output logic [11:0]         display,
    output logic [1:0]          tries,
    output logic                unlocked,
    output logic                locked_out,
    output logic                tone_req,
    output lock_pkg::tone_t     tone
);

    import lock_pkg::*;

    localparam int TW = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    typedef enum logic [1:0] {ST_IDLE, ST_OPEN, ST_SET, ST_LOCK} state_t;

    state_t        state_q;
    logic [11:0]   secret_q;
    logic [1:0]    tries_q;
    logic [1:0]    lock_idx_q;  // saturating lockout count
    logic [11:0]   bcd_q;       // countdown in bcd seconds
    logic [TW-1:0] tick_cnt_q;
    logic          enter_ok;
    logic          key_edit;

    function automatic logic [11:0] bcd_dec(input logic [11:0] v);
        logic [11:0] r;
        r = v;
        if (v[3:0] != 4'd0) begin
            r[3:0] = v[3:0] - 4'd1;
        end else begin
            r[3:0] = 4'd9;
            if (v[7:4] != 4'd0) begin
                r[7:4] = v[7:4] - 4'd1;
            end else begin
                r[7:4]  = 4'd9;
                r[11:8] = v[11:8] - 4'd1;
            end
        end
        return r;
    endfunction

    assign enter_ok = (key == KEY_ENTER) && (ent.count == 2'd3);
    assign key_edit = ((key <= KEY_9) && (ent.count != 2'd3))
                    || ((key == KEY_BACK) && (ent.count != 2'd0));  // same rule as the buffer

    assign ent.accept = (state_q == ST_IDLE) || (state_q == ST_SET);
    assign ent.clear  = key_valid && ent.accept
                      && (enter_ok || (key == KEY_CLEAR)
                          || ((state_q == ST_IDLE) && (key == KEY_SET)));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ST_IDLE;
            secret_q   <= DEFAULT_SECRET;
            tries_q    <= 2'd0;
            lock_idx_q <= 2'd0;
            bcd_q      <= 12'h000;
            tick_cnt_q <= '0;
            tone_req   <= 1'b0;
            tone       <= TONE_CLICK;
        end else begin
            tone_req <= 1'b0;
            case (state_q)
                ST_IDLE: if (key_valid) begin
                    if (enter_ok && (ent.digits == secret_q)) begin
                        state_q  <= ST_OPEN;
                        tries_q  <= 2'd0;
                        tone_req <= 1'b1;
                        tone     <= TONE_OK;
                    end else if (enter_ok) begin
                        tone_req <= 1'b1;
                        tone     <= TONE_FAIL;
                        if (tries_q == MAX_TRIES - 2'd1) begin
                            state_q    <= ST_LOCK;
                            tries_q    <= 2'd0;
                            bcd_q      <= LOCKOUT_BCD[lock_idx_q];
                            tick_cnt_q <= '0;
                            if (lock_idx_q != 2'd3) begin
                                lock_idx_q <= lock_idx_q + 2'd1;
                            end
                        end else begin
                            tries_q <= tries_q + 2'd1;
                        end
                    end else if (key == KEY_SET) begin
                        state_q  <= ST_SET;
                        tone_req <= 1'b1;
                        tone     <= TONE_CLICK;
                    end else if ((key == KEY_CLEAR) || key_edit) begin
                        if (key == KEY_CLEAR) begin
                            tries_q <= 2'd0;
                        end
                        tone_req <= 1'b1;
                        tone     <= TONE_CLICK;
                    end
                end
                ST_SET: if (key_valid) begin
                    if (enter_ok) begin
                        secret_q <= ent.digits;  // new code
                        tries_q  <= 2'd0;
                        state_q  <= ST_IDLE;
                        tone_req <= 1'b1;
                        tone     <= TONE_OK;
                    end else if ((key == KEY_CLEAR) || key_edit) begin
                        if (key == KEY_CLEAR) begin
                            state_q <= ST_IDLE;
                            tries_q <= 2'd0;
                        end
                        tone_req <= 1'b1;
                        tone     <= TONE_CLICK;
                    end
                end
                ST_OPEN: if (key_valid && (key == KEY_CLEAR)) begin
                    state_q  <= ST_IDLE;
                    tries_q  <= 2'd0;
                    tone_req <= 1'b1;
                    tone     <= TONE_CLICK;
                end
                default: begin  // lockout drops all keys
                    if (tick_cnt_q == TW'(TICK_CYCLES - 1)) begin
                        tick_cnt_q <= '0;
                        if (bcd_q == 12'h000) begin
                            state_q <= ST_IDLE;
                        end else begin
                            bcd_q    <= bcd_dec(bcd_q);
                            tone_req <= 1'b1;
                            tone     <= TONE_TICK;
                        end
                    end else begin
                        tick_cnt_q <= tick_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (state_q)
            ST_OPEN: display = DISP_OPEN;
            ST_SET:  display = (ent.count == 2'd0) ? DISP_SET : ent.digits;
            ST_LOCK: display = bcd_q;
            default: display = (ent.count == 2'd0) ? DISP_IDLE : ent.digits;
        endcase
    end

    assign tries      = tries_q;
    assign unlocked   = (state_q == ST_OPEN);
    assign locked_out = (state_q == ST_LOCK);

endmodule

`default_nettype wire

// ==== entry_buffer.sv ====
`default_nettype none

module entry_buffer (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire lock_pkg::key_t key,
    input  wire logic           key_valid,
    entry_if.buffer             ent
);

    import lock_pkg::*;

    logic [11:0] digits_q;
    logic [1:0]  count_q;
    logic        take;
    logic        is_digit;

    assign take     = key_valid && ent.accept;
    assign is_digit = (key <= KEY_9);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            digits_q <= {3{DIGIT_BLANK}};
            count_q  <= 2'd0;
        end else if (ent.clear) begin
            digits_q <= {3{DIGIT_BLANK}};  // wins over any key
            count_q  <= 2'd0;
        end else if (take) begin
            if (is_digit && (count_q != 2'd3)) begin
                digits_q <= {digits_q[7:0], key};  // new digit enters the low nibble
                count_q  <= count_q + 2'd1;
            end else if ((key == KEY_BACK) && (count_q != 2'd0)) begin
                digits_q <= {DIGIT_BLANK, digits_q[11:4]};  // drop newest
                count_q  <= count_q - 2'd1;
            end
            // digit with full buffer is ignored
        end
    end

    assign ent.digits = digits_q;
    assign ent.count  = count_q;

endmodule

`default_nettype wire

// ==== key_decoder.sv ====
`default_nettype none

module key_decoder (
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  wire logic [15:0]   onehot,
    output lock_pkg::key_t     key,
    output logic               key_valid
);

    import lock_pkg::*;

    logic [15:0] onehot_q;  // sampled keypad word
    logic [15:0] prev_q;    // word one cycle earlier
    logic        single;
    key_t        key_c;

    // exactly one bit set
    assign single = (onehot_q != 16'h0000) && ((onehot_q & (onehot_q - 16'd1)) == 16'h0000);

    // pad wiring of the board
    always_comb begin
        case (onehot_q)
            16'h0001: key_c = KEY_ENTER;
            16'h0008: key_c = KEY_0;
            16'h0010: key_c = KEY_SET;
            16'h0020: key_c = KEY_3;
            16'h0040: key_c = KEY_2;
            16'h0080: key_c = KEY_1;
            16'h0100: key_c = KEY_CLEAR;
            16'h0200: key_c = KEY_6;
            16'h0400: key_c = KEY_5;
            16'h0800: key_c = KEY_4;
            16'h1000: key_c = KEY_BACK;
            16'h2000: key_c = KEY_9;
            16'h4000: key_c = KEY_8;
            16'h8000: key_c = KEY_7;
            default:  key_c = KEY_NONE;  // unused positions
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            onehot_q  <= 16'h0000;
            prev_q    <= 16'h0000;
            key_valid <= 1'b0;
        end else begin
            onehot_q  <= onehot;
            prev_q    <= onehot_q;
            key_valid <= single && (onehot_q != prev_q);  // held key gives no repeat
        end
    end

    always_ff @(posedge clk) begin
        key <= key_c;
    end

endmodule

`default_nettype wire

// ==== entry_if.sv ====
`default_nettype none

interface entry_if;

    logic [11:0] digits;  // newest digit in low nibble
    logic [1:0]  count;   // digits held, 0 to 3
    logic        accept;  // buffer may take keys
    logic        clear;   // blank the buffer next edge

    modport buffer (
        output digits, count,
        input  accept, clear
    );

    modport ctrl (
        input  digits, count,
        output accept, clear
    );

endinterface

`default_nettype wire

// ==== lock_pkg.sv ====
`default_nettype none

package lock_pkg;

    // key codes, digits keep their own value
    typedef enum logic [3:0] {
        KEY_0     = 4'd0,
        KEY_1     = 4'd1,
        KEY_2     = 4'd2,
        KEY_3     = 4'd3,
        KEY_4     = 4'd4,
        KEY_5     = 4'd5,
        KEY_6     = 4'd6,
        KEY_7     = 4'd7,
        KEY_8     = 4'd8,
        KEY_9     = 4'd9,
        KEY_ENTER = 4'd10,
        KEY_BACK  = 4'd11,
        KEY_CLEAR = 4'd12,
        KEY_SET   = 4'd13,
        KEY_NONE  = 4'd15
    } key_t;

    typedef enum logic [1:0] {
        TONE_CLICK,  // key feedback
        TONE_OK,     // open or code stored
        TONE_FAIL,   // wrong code
        TONE_TICK    // lockout second
    } tone_t;

    localparam logic [3:0]  DIGIT_BLANK = 4'hF;
    localparam logic [11:0] DISP_OPEN   = 12'hBCC;
    localparam logic [11:0] DISP_SET    = 12'hDDD;
    localparam logic [11:0] DISP_IDLE   = 12'hFFF;

    // lockout start in bcd seconds, indexed by lockouts so far
    localparam logic [11:0] LOCKOUT_BCD [0:3] = '{12'h005, 12'h010, 12'h020, 12'h060};

    localparam logic [1:0] MAX_TRIES = 2'd3;

endpackage

`default_nettype wire
